//--- avr_io_subsys.f
+incdir+hdl
+incdir+tests
hdl/io_bus_pkg.sv
hdl/tim_pkg.sv
hdl/avr_pio.sv
hdl/tim0_regs.sv
hdl/tim0_counter.sv
hdl/avr_io_subsys.sv
tests/tb_avr_io_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f avr_io_subsys.f --top-module tb_avr_io_subsys \
    && ./obj_dir/Vtb_avr_io_subsys \
    || exit 1

//--- tests/tb_avr_io_tasks.svh
/*
 * Bus access tasks, value checks and directed tests
 * of the I/O subsystem testbench
 */
`ifndef TB_AVR_IO_TASKS_SVH
`define TB_AVR_IO_TASKS_SVH

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit taken
task automatic rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++)
    begin
        lfsr_state = lfsr_next(lfsr_state);
        b = {b[6:0], lfsr_state[0]};
    end
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp)
    else
    begin
        $display("FAILED %s expected 0x%02h got 0x%02h", name, exp, got);
        $display("TESTBENCH FAILED");
        $fatal(1, "value mismatch");
    end
endtask

task automatic check_true(input string what, input logic cond);
    assert (cond)
    else
    begin
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "check failed");
    end
endtask

// Write lands on the second edge, outputs sampled at the next falling edge
task automatic io_write(input logic [5:0] reg_addr, input logic [7:0] value);
    @(posedge clk);
    bus <= '{addr: reg_addr, wdata: value, wr: 1'b1, rd: 1'b0};
    @(posedge clk);
    bus <= '0;
    @(negedge clk);
endtask

// Read data is valid for one cycle after the edge that takes rd
task automatic io_read(input logic [5:0] reg_addr, output logic [7:0] value);
    @(posedge clk);
    bus <= '{addr: reg_addr, wdata: 8'h00, wr: 1'b0, rd: 1'b1};
    @(posedge clk);
    bus <= '0;
    @(negedge clk);
    value = rdata;
endtask

task automatic read_expect(input string name, input logic [5:0] reg_addr,
                           input logic [7:0] exp);
    logic [7:0] got;
    io_read(reg_addr, got);
    check_byte(name, got, exp);
endtask

task automatic check_reset_state();
    logic [5:0] regs [11] = '{`AVR_PINB_ADDR, `AVR_DDRB_ADDR, `AVR_PORTB_ADDR,
                              `AVR_PIND_ADDR, `AVR_DDRD_ADDR, `AVR_PORTD_ADDR,
                              `AVR_TIFR0_ADDR, `AVR_TCCR0A_ADDR, `AVR_TCCR0B_ADDR,
                              `AVR_TCNT0_ADDR, `AVR_OCR0A_ADDR};
    check_byte("rdata", rdata, 8'h00);
    check_byte("pb_out", pb_out, 8'h00);
    check_byte("pb_oe", pb_oe, 8'h00);
    check_byte("pd_out", pd_out, 8'h00);
    check_byte("pd_oe", pd_oe, 8'h00);
    check_byte("oc0a", {7'b0, oc0a}, 8'h00);
    check_byte("oc0a_en", {7'b0, oc0a_en}, 8'h00);
    foreach (regs[i])
        read_expect($sformatf("rdata at 0x%02h", regs[i]), regs[i], 8'h00);
endtask

task automatic port_readback();
    logic [7:0] d;
    logic [7:0] b;
    logic [7:0] e;
    for (int i = 0; i < 4; i++)
    begin
        rand_byte(d);
        rand_byte(b);
        rand_byte(e);
        io_write(`AVR_PORTD_ADDR, d);
        io_write(`AVR_DDRD_ADDR, e);
        io_write(`AVR_DDRB_ADDR, b);
        io_write(`AVR_PORTB_ADDR, b);
        check_byte("pd_out", pd_out, d);
        check_byte("pd_oe", pd_oe, e);
        // Port B has only bits 7:4
        check_byte("pb_oe", pb_oe, b & 8'hF0);
        check_byte("pb_out", pb_out, b & 8'hF0);
        read_expect("PORTD", `AVR_PORTD_ADDR, d);
        read_expect("DDRD", `AVR_DDRD_ADDR, e);
        read_expect("DDRB", `AVR_DDRB_ADDR, b & 8'hF0);
    end
endtask

task automatic pin_toggle_and_sync();
    logic [7:0] p;
    logic [7:0] t;
    logic [7:0] v;
    rand_byte(p);
    rand_byte(t);
    io_write(`AVR_PORTD_ADDR, p);
    io_write(`AVR_PIND_ADDR, t);
    check_byte("pd_out", pd_out, p ^ t);
    read_expect("PORTD", `AVR_PORTD_ADDR, p ^ t);
    for (int i = 0; i < 4; i++)
    begin
        rand_byte(v);
        @(posedge clk);
        pd_in <= v;
        pb_in <= ~v;
        // Two idle edges through the synchronizer
        repeat (2) @(posedge clk);
        read_expect("PIND", `AVR_PIND_ADDR, v);
        read_expect("PINB", `AVR_PINB_ADDR, ~v & 8'hF0);
    end
endtask

task automatic timer_overflow();
    logic [7:0] cnt;
    io_write(`AVR_TCCR0A_ADDR, 8'h00);
    io_write(`AVR_TCNT0_ADDR, 8'hF0);
    io_write(`AVR_TCCR0B_ADDR, 8'h01);
    repeat (40) @(posedge clk);
    io_write(`AVR_TCCR0B_ADDR, 8'h00);
    // OCR0A is still zero, so the wrap also hits the compare value
    read_expect("TIFR0", `AVR_TIFR0_ADDR, 8'h03);
    io_write(`AVR_TIFR0_ADDR, 8'h01);
    read_expect("TIFR0", `AVR_TIFR0_ADDR, 8'h02);
    io_write(`AVR_TIFR0_ADDR, 8'h02);
    read_expect("TIFR0", `AVR_TIFR0_ADDR, 8'h00);
    io_read(`AVR_TCNT0_ADDR, cnt);
    check_true("TCNT0 did not wrap past 0xFF", cnt < 8'h40);
endtask

task automatic timer_ctc_toggle();
    logic       prev;
    int         gap;
    int         toggles;
    logic [7:0] cnt;
    io_write(`AVR_TCNT0_ADDR, 8'h00);
    io_write(`AVR_OCR0A_ADDR, 8'd9);
    // COM0A toggle in bits 7:6, CTC in bit 1
    io_write(`AVR_TCCR0A_ADDR, 8'h42);
    check_byte("oc0a_en", {7'b0, oc0a_en}, 8'h01);
    io_write(`AVR_TCCR0B_ADDR, 8'h01);
    for (int i = 0; i < 30 && !oc0a; i++)
        @(negedge clk);
    check_true("oc0a never toggled in CTC mode", oc0a);
    prev    = oc0a;
    gap     = 0;
    toggles = 0;
    while (toggles < 5)
    begin
        @(negedge clk);
        gap++;
        check_true("oc0a held its level for more than 10 cycles", gap <= 10);
        if (oc0a !== prev)
        begin
            check_byte("oc0a toggle interval", 8'(gap), 8'd10);
            prev = oc0a;
            gap  = 0;
            toggles++;
        end
    end
    read_expect("TIFR0", `AVR_TIFR0_ADDR, 8'h02);
    for (int i = 0; i < 12; i++)
    begin
        io_read(`AVR_TCNT0_ADDR, cnt);
        check_true("TCNT0 rose above OCR0A in CTC mode", cnt <= 8'd9);
    end
endtask

task automatic timer_hold_stopped();
    logic [7:0] v;
    io_write(`AVR_TCCR0B_ADDR, 8'h00);
    io_write(`AVR_TCCR0A_ADDR, 8'h00);
    rand_byte(v);
    io_write(`AVR_TCNT0_ADDR, v);
    read_expect("TCNT0", `AVR_TCNT0_ADDR, v);
    repeat (100) @(posedge clk);
    read_expect("TCNT0", `AVR_TCNT0_ADDR, v);
endtask

`endif

//--- tests/tb_avr_io_subsys.sv
/*
 * Testbench for the AVR I/O peripheral subsystem: clock, reset,
 * watchdog and the directed test sequence
 */
`timescale 1ns/1ps
`default_nettype none

`include "avr_io_consts.svh"

module tb_avr_io_subsys;

    localparam int CLK_PERIOD = 20;
    // Cycle budget of each test in run order
    localparam int TEST_CYCLES   = 40 + 80 + 60 + 80 + 180 + 130;
    localparam int MARGIN_CYCLES = 200;

    logic                clk;
    logic                rst;
    io_bus_pkg::io_req_t bus;
    logic [7:0]          rdata;
    logic [7:0]          pb_in;
    logic [7:0]          pb_out;
    logic [7:0]          pb_oe;
    logic [7:0]          pd_in;
    logic [7:0]          pd_out;
    logic [7:0]          pd_oe;
    logic                oc0a;
    logic                oc0a_en;
    logic [31:0]         lfsr_state;

    avr_io_subsys i_dut (
        .clk(clk), .rst(rst), .bus(bus), .rdata(rdata),
        .pb_in(pb_in), .pb_out(pb_out), .pb_oe(pb_oe),
        .pd_in(pd_in), .pd_out(pd_out), .pd_oe(pd_oe),
        .oc0a(oc0a), .oc0a_en(oc0a_en)
    );

    `include "tb_avr_io_tasks.svh"

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Stops a run that hangs
    initial
    begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
        $display("Watchdog timeout, the tests did not finish in time");
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        rst        = 1'b1;
        bus        = '0;
        pb_in      = 8'h00;
        pd_in      = 8'h00;
        lfsr_state = 32'd79649;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_reset_state();
        port_readback();
        pin_toggle_and_sync();
        timer_overflow();
        timer_ctc_toggle();
        timer_hold_stopped();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/avr_io_subsys.sv
/*
 * Peripheral side of the AVR I/O bus: ports B and D and timer 0,
 * read bytes of all blocks merged by OR
 */
`timescale 1ns/1ps
`default_nettype none

`include "avr_io_consts.svh"

module avr_io_subsys (
    input  logic                clk,
    input  logic                rst,
    input  io_bus_pkg::io_req_t bus,
    output logic [7:0]          rdata,
    input  logic [7:0]          pb_in,
    output logic [7:0]          pb_out,
    output logic [7:0]          pb_oe,
    input  logic [7:0]          pd_in,
    output logic [7:0]          pd_out,
    output logic [7:0]          pd_oe,
    output logic                oc0a,
    output logic                oc0a_en
);

    logic [7:0]         pb_rdata;
    logic [7:0]         pd_rdata;
    logic [7:0]         tim_rdata;
    tim_pkg::tim_ctrl_t tim_ctrl;
    tim_pkg::tim_load_t tim_load;
    tim_pkg::tim_stat_t tim_stat;

    avr_pio #(
        .PIN_ADDR  (`AVR_PINB_ADDR),
        .DDR_ADDR  (`AVR_DDRB_ADDR),
        .PORT_ADDR (`AVR_PORTB_ADDR),
        .PIN_MASK  (`AVR_PORTB_MASK)
    ) pio_b (
        .clk(clk), .rst(rst), .bus(bus), .rdata(pb_rdata),
        .pins_in(pb_in), .port_out(pb_out), .port_oe(pb_oe)
    );

    avr_pio #(
        .PIN_ADDR  (`AVR_PIND_ADDR),
        .DDR_ADDR  (`AVR_DDRD_ADDR),
        .PORT_ADDR (`AVR_PORTD_ADDR),
        .PIN_MASK  (`AVR_PORTD_MASK)
    ) pio_d (
        .clk(clk), .rst(rst), .bus(bus), .rdata(pd_rdata),
        .pins_in(pd_in), .port_out(pd_out), .port_oe(pd_oe)
    );

    tim0_regs i_tim0_regs (
        .clk(clk), .rst(rst), .bus(bus), .rdata(tim_rdata),
        .stat(tim_stat), .ctrl(tim_ctrl), .load(tim_load)
    );

    // OC0A goes to a pin on the board while oc0a_en is high
    tim0_counter i_tim0_counter (
        .clk(clk), .rst(rst), .ctrl(tim_ctrl), .load(tim_load),
        .stat(tim_stat), .oc0a(oc0a), .oc0a_en(oc0a_en)
    );

    // Unselected blocks return zero
    assign rdata = pb_rdata | pd_rdata | tim_rdata;

endmodule

`default_nettype wire

//--- hdl/tim0_counter.sv
/*
 * Timer 0 counting core: shared prescaler, tick select, 8-bit
 * counter with CTC clear, overflow and compare events, OC0A output
 */
`timescale 1ns/1ps
`default_nettype none

`include "avr_io_consts.svh"

module tim0_counter (
    input  logic               clk,
    input  logic               rst,
    input  tim_pkg::tim_ctrl_t ctrl,
    input  tim_pkg::tim_load_t load,
    output tim_pkg::tim_stat_t stat,
    output logic               oc0a,
    output logic               oc0a_en
);

    logic [`AVR_PRESC_WIDTH-1:0] presc;
    logic                        tick;
    logic [7:0]                  tcnt;
    logic                        match;
    logic                        ovf_q;
    logic                        cmpa_q;

    // Free-running from reset, shared by all dividers
    always_ff @(posedge clk)
    begin
        if (rst)
            presc <= '0;
        else
            presc <= presc + 1'b1;
    end

    always_comb
    begin
        case (ctrl.cs)
            tim_pkg::cs_div1:    tick = 1'b1;
            tim_pkg::cs_div8:    tick = &presc[`AVR_PRESC_DIV8_BITS-1:0];
            tim_pkg::cs_div64:   tick = &presc[`AVR_PRESC_DIV64_BITS-1:0];
            tim_pkg::cs_div256:  tick = &presc[`AVR_PRESC_DIV256_BITS-1:0];
            tim_pkg::cs_div1024: tick = &presc[`AVR_PRESC_DIV1024_BITS-1:0];
            default:             tick = 1'b0;
        endcase
    end

    // A TCNT0 write suppresses the event on its own cycle
    assign match = tick && !load.load && (tcnt == ctrl.ocra);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tcnt   <= '0;
            ovf_q  <= 1'b0;
            cmpa_q <= 1'b0;
            oc0a   <= 1'b0;
        end
        else
        begin
            if (load.load)
                tcnt <= load.value;
            else if (tick)
                tcnt <= (ctrl.wgm == tim_pkg::wgm_ctc && tcnt == ctrl.ocra) ? 8'h00 : tcnt + 1'b1;
            ovf_q  <= tick && !load.load && ctrl.wgm == tim_pkg::wgm_normal && tcnt == 8'hFF;
            cmpa_q <= match;
            if (match)
            begin
                case (ctrl.com_a)
                    tim_pkg::com_toggle: oc0a <= ~oc0a;
                    tim_pkg::com_clear:  oc0a <= 1'b0;
                    tim_pkg::com_set:    oc0a <= 1'b1;
                    default:             oc0a <= oc0a;
                endcase
            end
        end
    end

    assign oc0a_en = (ctrl.com_a != tim_pkg::com_disconnect);
    assign stat    = '{tcnt: tcnt, ovf: ovf_q, cmpa: cmpa_q};

    // In CTC mode the count stays at or below the top value it had
    a_ctc_bound: assert property (@(posedge clk) disable iff (rst)
        (ctrl.wgm == tim_pkg::wgm_ctc && tcnt <= ctrl.ocra && !load.load)
        |=> (tcnt <= $past(ctrl.ocra)));

endmodule

`default_nettype wire

//--- hdl/tim0_regs.sv
/*
 * Timer 0 register file: TCCR0A, TCCR0B, OCR0A and TIFR0,
 * TCNT0 load strobe and the registered read mux
 */
`timescale 1ns/1ps
`default_nettype none

`include "avr_io_consts.svh"

module tim0_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  io_bus_pkg::io_req_t   bus,
    output logic [7:0]            rdata,
    input  tim_pkg::tim_stat_t    stat,
    output tim_pkg::tim_ctrl_t    ctrl,
    output tim_pkg::tim_load_t    load
);

    logic [1:0] com0a_q;
    logic       ctc_q;
    logic [2:0] cs_q;
    logic [7:0] ocr0a_q;
    // TOV0 in bit 0, OCF0A in bit 1
    logic [1:0] tifr0_q;
    logic [1:0] flag_clr;

    assign flag_clr = (bus.wr && bus.addr == `AVR_TIFR0_ADDR) ? bus.wdata[1:0] : 2'b00;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            com0a_q <= '0;
            ctc_q   <= 1'b0;
            cs_q    <= '0;
            ocr0a_q <= '0;
            tifr0_q <= '0;
        end
        else
        begin
            if (bus.wr && bus.addr == `AVR_TCCR0A_ADDR)
            begin
                com0a_q <= bus.wdata[7:6];
                ctc_q   <= bus.wdata[1];
            end
            if (bus.wr && bus.addr == `AVR_TCCR0B_ADDR)
                cs_q <= bus.wdata[2:0];
            if (bus.wr && bus.addr == `AVR_OCR0A_ADDR)
                ocr0a_q <= bus.wdata;
            // A new event wins over a clear in the same cycle
            tifr0_q <= (tifr0_q & ~flag_clr) | {stat.cmpa, stat.ovf};
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || !bus.rd)
            rdata <= '0;
        else
        begin
            case (bus.addr)
                `AVR_TIFR0_ADDR:  rdata <= {6'b0, tifr0_q};
                `AVR_TCCR0A_ADDR: rdata <= {com0a_q, 4'b0, ctc_q, 1'b0};
                `AVR_TCCR0B_ADDR: rdata <= {5'b0, cs_q};
                `AVR_TCNT0_ADDR:  rdata <= stat.tcnt;
                `AVR_OCR0A_ADDR:  rdata <= ocr0a_q;
                default:          rdata <= '0;
            endcase
        end
    end

    assign ctrl.cs    = tim_pkg::clk_sel_t'(cs_q);
    assign ctrl.wgm   = tim_pkg::wgm_t'(ctc_q);
    assign ctrl.com_a = tim_pkg::com_t'(com0a_q);
    assign ctrl.ocra  = ocr0a_q;

    // Counter load strobe, same edge as the TCNT0 write
    assign load.load  = bus.wr && (bus.addr == `AVR_TCNT0_ADDR);
    assign load.value = bus.wdata;

    a_load_pulse: assert property (@(posedge clk) disable iff (rst) load.load |=> !load.load);

endmodule

`default_nettype wire

//--- hdl/avr_pio.sv
/*
 * General-purpose I/O port with PORT, DDR and PIN registers.
 * Writing ones to PIN toggles the matching PORT bits.
 */
`timescale 1ns/1ps
`default_nettype none

module avr_pio #(
    parameter logic [5:0] PIN_ADDR  = 6'h03,
    parameter logic [5:0] DDR_ADDR  = 6'h04,
    parameter logic [5:0] PORT_ADDR = 6'h05,
    parameter logic [7:0] PIN_MASK  = 8'hFF
) (
    input  logic                clk,
    input  logic                rst,
    input  io_bus_pkg::io_req_t bus,
    output logic [7:0]          rdata,
    input  logic [7:0]          pins_in,
    output logic [7:0]          port_out,
    output logic [7:0]          port_oe
);

    logic [7:0] port_q;
    logic [7:0] ddr_q;
    logic [7:0] pin_meta;
    logic [7:0] pin_sync;

    // Two-flop synchronizer on the pad inputs
    always_ff @(posedge clk)
    begin
        pin_meta <= pins_in;
        pin_sync <= pin_meta;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            port_q <= '0;
            ddr_q  <= '0;
        end
        else if (bus.wr)
        begin
            if (bus.addr == PORT_ADDR)
                port_q <= bus.wdata & PIN_MASK;
            else if (bus.addr == PIN_ADDR)
                port_q <= port_q ^ (bus.wdata & PIN_MASK);
            if (bus.addr == DDR_ADDR)
                ddr_q <= bus.wdata & PIN_MASK;
        end
    end

    // Read byte is zero unless this port was addressed
    always_ff @(posedge clk)
    begin
        if (rst || !bus.rd)
            rdata <= '0;
        else if (bus.addr == PIN_ADDR)
            rdata <= pin_sync & PIN_MASK;
        else if (bus.addr == DDR_ADDR)
            rdata <= ddr_q;
        else if (bus.addr == PORT_ADDR)
            rdata <= port_q;
        else
            rdata <= '0;
    end

    assign port_out = port_q;
    assign port_oe  = ddr_q;

    // Bus master never issues a read and a write together
    a_no_rd_wr: assert property (@(posedge clk) disable iff (rst) !(bus.wr && bus.rd));

endmodule

`default_nettype wire

//--- hdl/tim_pkg.sv
/*
 * Timer 0 types: control fields, counter load and status events
 */
`default_nettype none

package tim_pkg;

    // Codes 6 and 7 are treated as stopped
    typedef enum logic [2:0] {
        cs_stopped = 3'd0,
        cs_div1    = 3'd1,
        cs_div8    = 3'd2,
        cs_div64   = 3'd3,
        cs_div256  = 3'd4,
        cs_div1024 = 3'd5
    } clk_sel_t;

    typedef enum logic {
        wgm_normal = 1'b0,
        wgm_ctc    = 1'b1
    } wgm_t;

    // Action on OC0A at compare match
    typedef enum logic [1:0] {
        com_disconnect = 2'd0,
        com_toggle     = 2'd1,
        com_clear      = 2'd2,
        com_set        = 2'd3
    } com_t;

    typedef struct packed {
        clk_sel_t   cs;
        wgm_t       wgm;
        com_t       com_a;
        logic [7:0] ocra;
    } tim_ctrl_t;

    typedef struct packed {
        logic       load;
        logic [7:0] value;
    } tim_load_t;

    typedef struct packed {
        logic [7:0] tcnt;
        logic       ovf;
        logic       cmpa;
    } tim_stat_t;

endpackage

`default_nettype wire

//--- hdl/io_bus_pkg.sv
/*
 * I/O register bus request as driven by the bus master
 */
`default_nettype none

package io_bus_pkg;

    // One access on the 6-bit I/O space
    typedef struct packed {
        logic [5:0] addr;
        logic [7:0] wdata;
        logic       wr;
        logic       rd;
    } io_req_t;

endpackage

`default_nettype wire

//--- hdl/avr_io_consts.svh
/*
 * I/O register map of the peripheral subsystem, implemented port
 * bits and prescaler tap widths
 */
`ifndef AVR_IO_CONSTS_SVH
`define AVR_IO_CONSTS_SVH

// Port B and port D
`define AVR_PINB_ADDR   6'h03
`define AVR_DDRB_ADDR   6'h04
`define AVR_PORTB_ADDR  6'h05
`define AVR_PIND_ADDR   6'h09
`define AVR_DDRD_ADDR   6'h0A
`define AVR_PORTD_ADDR  6'h0B
`define AVR_PORTB_MASK  8'hF0
`define AVR_PORTD_MASK  8'hFF

// Timer 0
`define AVR_TIFR0_ADDR  6'h15
`define AVR_TCCR0A_ADDR 6'h24
`define AVR_TCCR0B_ADDR 6'h25
`define AVR_TCNT0_ADDR  6'h26
`define AVR_OCR0A_ADDR  6'h27

// Prescaler width, and low bits that wrap for each divider
`define AVR_PRESC_WIDTH       10
`define AVR_PRESC_DIV8_BITS   3
`define AVR_PRESC_DIV64_BITS  6
`define AVR_PRESC_DIV256_BITS 8
`define AVR_PRESC_DIV1024_BITS 10

`endif
